// File: files.f
+incdir+hdl
hdl/monsterPkg.sv
hdl/monsterRegs.sv
hdl/borderSensor.sv
hdl/lfsrRandom.sv
hdl/monsterMover.sv
hdl/monsterTop.sv
test/monsterTb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the monster mover testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f files.f --top-module monsterTb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/VmonsterTb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

echo "simulation finished cleanly"
exit 0

// File: test/monsterTb.sv
`default_nettype none

`include "monster_config.svh"

module monsterTb;

    timeunit 1ns;
    timeprecision 100ps;

    logic        clk;
    logic        resetN;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  adr;
    logic [15:0] datW;
    logic [15:0] datR;
    logic        ack;
    logic        startOfFrame;
    logic        missileHit;

    // model of the mover state, updated after every frame pulse
    monsterPkg::fixedT mPosX;
    monsterPkg::fixedT mPosY;
    monsterPkg::speedT mVx;
    monsterPkg::speedT mVy;
    monsterPkg::pixelT mMinX;
    monsterPkg::pixelT mMaxX;
    monsterPkg::pixelT mMinY;
    monsterPkg::pixelT mMaxY;
    logic [15:0]       mLfsr;
    logic              mFrozen;  // idle or hit, the monster does not move
    integer            seed;

    monsterTop UUT (
        .clk(clk), .resetN(resetN),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datW(datW),
        .datR(datR), .ack(ack),
        .startOfFrame(startOfFrame), .missileHit(missileHit)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 125 MHz
    end

    // next LFSR value, taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] l);
        return {l[14:0], l[15] ^ l[13] ^ l[12] ^ l[10]};
    endfunction

    // whole pixel of a fixed point value as the bus shows it, sign extended
    function automatic logic [15:0] pixelWord(input monsterPkg::fixedT f);
        monsterPkg::pixelT p;
        p = monsterPkg::pixelT'(f >>> `MON_FRAC_BITS);
        return 16'(p);
    endfunction

    // one frame of the mover by the bounce and deflection rules
    function automatic void predictFrame(
        input  monsterPkg::fixedT px, input monsterPkg::fixedT py,
        input  monsterPkg::speedT vx, input monsterPkg::speedT vy,
        input  monsterPkg::pixelT loX, input monsterPkg::pixelT hiX,
        input  monsterPkg::pixelT loY, input monsterPkg::pixelT hiY,
        input  logic rnd, input logic frozen,
        output monsterPkg::fixedT npx, output monsterPkg::fixedT npy,
        output monsterPkg::speedT nvx, output monsterPkg::speedT nvy);
        integer pixX;
        integer pixY;
        logic   yHit;
        logic   xHit;
        pixX = integer'(monsterPkg::pixelT'(px >>> `MON_FRAC_BITS));
        pixY = integer'(monsterPkg::pixelT'(py >>> `MON_FRAC_BITS));
        yHit = ((pixY <= integer'(loY)) && vy < 0)
               || ((pixY + `MON_SPRITE_H >= integer'(hiY)) && vy > 0);
        xHit = ((pixX <= integer'(loX)) && vx < 0)
               || ((pixX + `MON_SPRITE_W >= integer'(hiX)) && vx > 0);
        nvx = vx;
        nvy = vy;
        npx = px;
        npy = py;
        if (!frozen) begin
            if (xHit && yHit) begin      // a corner ignores the random bit
                nvx = -vx;
                nvy = -vy;
            end else if (yHit) begin
                nvy = -vy;
                if (rnd) nvx = -vx;
            end else if (xHit) begin
                nvx = -vx;
                if (rnd) nvy = -vy;
            end
            npx = px + monsterPkg::fixedT'(nvx);
            npy = py + monsterPkg::fixedT'(nvy);
        end
    endfunction

    task automatic checkValue(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("timed out waiting for %s", what);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    // one classic cycle, returns the read data latched with ack
    task automatic busCycle(input logic write, input logic [3:0] a, input logic [15:0] d,
                            output logic [15:0] q);
        int waitCount;
        waitCount = 0;
        @(negedge clk);
        cyc  = 1'b1;
        stb  = 1'b1;
        we   = write;
        adr  = a;
        datW = d;
        @(negedge clk);
        while (!ack) begin
            if (waitCount == 20) reportTimeout("wishbone ack");
            waitCount++;
            @(negedge clk);
        end
        q    = datR;
        cyc  = 1'b0;
        stb  = 1'b0;
        we   = 1'b0;
    endtask

    task automatic wbWrite(input logic [3:0] a, input logic [15:0] d);
        logic [15:0] dummy;
        busCycle(1'b1, a, d, dummy);
    endtask

    task automatic wbRead(input logic [3:0] a, output logic [15:0] q);
        busCycle(1'b0, a, 16'h0000, q);
    endtask

    task automatic expectRead(input string name, input logic [3:0] a, input logic [15:0] exp);
        logic [15:0] q;
        wbRead(a, q);
        checkValue(name, q, exp);
    endtask

    task automatic checkPosition;
        expectRead("posX", monsterPkg::REG_START_X, pixelWord(mPosX));
        expectRead("posY", monsterPkg::REG_START_Y, pixelWord(mPosY));
    endtask

    task automatic setBounds(input monsterPkg::pixelT loX, input monsterPkg::pixelT hiX,
                             input monsterPkg::pixelT loY, input monsterPkg::pixelT hiY);
        wbWrite(monsterPkg::REG_MIN_X, 16'(loX));
        wbWrite(monsterPkg::REG_MAX_X, 16'(hiX));
        wbWrite(monsterPkg::REG_MIN_Y, 16'(loY));
        wbWrite(monsterPkg::REG_MAX_Y, 16'(hiY));
        mMinX = loX;
        mMaxX = hiX;
        mMinY = loY;
        mMaxY = hiY;
    endtask

    // loads a start position and speed and enables the mover
    task automatic loadMonster(input monsterPkg::pixelT x, input monsterPkg::pixelT y,
                               input monsterPkg::speedT vx, input monsterPkg::speedT vy);
        wbWrite(monsterPkg::REG_START_X, 16'(x));
        wbWrite(monsterPkg::REG_START_Y, 16'(y));
        wbWrite(monsterPkg::REG_SPEED_X, 16'(vx));
        wbWrite(monsterPkg::REG_SPEED_Y, 16'(vy));
        wbWrite(monsterPkg::REG_CTRL, 16'h0003);
        mPosX   = monsterPkg::fixedT'(x) <<< `MON_FRAC_BITS;
        mPosY   = monsterPkg::fixedT'(y) <<< `MON_FRAC_BITS;
        mVx     = vx;
        mVy     = vy;
        mFrozen = 1'b0;
        checkPosition();
    endtask

    task automatic frame;
        @(negedge clk);
        startOfFrame = 1'b1;
        @(negedge clk);
        startOfFrame = 1'b0;
        predictFrame(mPosX, mPosY, mVx, mVy, mMinX, mMaxX, mMinY, mMaxY,
                     mLfsr[0], mFrozen, mPosX, mPosY, mVx, mVy);
        mLfsr = lfsrNext(mLfsr);     // runs in every state
        checkPosition();
    endtask

    task automatic randomRun(input int frames);
        monsterPkg::pixelT x;
        monsterPkg::pixelT y;
        monsterPkg::speedT vx;
        monsterPkg::speedT vy;
        x  = monsterPkg::pixelT'(120 + ($random(seed) & 31));
        y  = monsterPkg::pixelT'(60 + ($random(seed) & 31));
        vx = monsterPkg::speedT'(40 + ($random(seed) & 63));
        vy = monsterPkg::speedT'(40 + ($random(seed) & 63));
        if ($random(seed) & 1) vx = -vx;
        if ($random(seed) & 1) vy = -vy;
        loadMonster(x, y, vx, vy);
        repeat (frames) frame();
    endtask

    initial begin
        seed         = 39;
        resetN       = 1'b0;
        cyc          = 1'b0;
        stb          = 1'b0;
        we           = 1'b0;
        adr          = 4'h0;
        datW         = 16'h0000;
        startOfFrame = 1'b0;
        missileHit   = 1'b0;
        mPosX        = monsterPkg::fixedT'(`MON_INIT_X * 64);
        mPosY        = monsterPkg::fixedT'(`MON_INIT_Y * 64);
        mVx          = monsterPkg::speedT'(`MON_INIT_VX);
        mVy          = monsterPkg::speedT'(`MON_INIT_VY);
        mMinX        = `MON_MIN_X;
        mMaxX        = `MON_MAX_X;
        mMinY        = `MON_MIN_Y;
        mMaxY        = `MON_MAX_Y;
        mLfsr        = `MON_LFSR_SEED;
        mFrozen      = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        resetN = 1'b1;

        // reset values, then write and read back each register
        expectRead("ctrl", monsterPkg::REG_CTRL, 16'h0000);
        expectRead("status", monsterPkg::REG_STATUS, 16'h0000);
        checkPosition();
        expectRead("speedX", monsterPkg::REG_SPEED_X, 16'(`MON_INIT_VX));
        expectRead("speedY", monsterPkg::REG_SPEED_Y, 16'(`MON_INIT_VY));
        expectRead("minX", monsterPkg::REG_MIN_X, 16'(`MON_MIN_X));
        expectRead("maxX", monsterPkg::REG_MAX_X, 16'(`MON_MAX_X));
        expectRead("minY", monsterPkg::REG_MIN_Y, 16'(`MON_MIN_Y));
        expectRead("maxY", monsterPkg::REG_MAX_Y, 16'(`MON_MAX_Y));
        wbWrite(monsterPkg::REG_SPEED_X, 16'h0025);
        expectRead("speedX", monsterPkg::REG_SPEED_X, 16'h0025);
        wbWrite(monsterPkg::REG_SPEED_Y, 16'h00F3);   // negative, comes back sign extended
        expectRead("speedY", monsterPkg::REG_SPEED_Y, 16'hFFF3);
        setBounds(11'd12, 11'd345, 11'd23, 11'd456);
        expectRead("minX", monsterPkg::REG_MIN_X, 16'd12);
        expectRead("maxX", monsterPkg::REG_MAX_X, 16'd345);
        expectRead("minY", monsterPkg::REG_MIN_Y, 16'd23);
        expectRead("maxY", monsterPkg::REG_MAX_Y, 16'd456);
        expectRead("unmapped", 4'hC, 16'h0000);
        setBounds(`MON_MIN_X, `MON_MAX_X, `MON_MIN_Y, `MON_MAX_Y);

        // straight line far from every border
        loadMonster(11'd300, 11'd200, 8'sd40, 8'sd20);
        expectRead("ctrl", monsterPkg::REG_CTRL, 16'h0001);
        repeat (20) frame();

        // small playfield, top left corner, bottom right corner, then random runs
        setBounds(11'd100, 11'd220, 11'd50, 11'd150);
        loadMonster(11'd101, 11'd51, -8'sd90, -8'sd70);
        repeat (10) frame();
        loadMonster(11'd187, 11'd117, 8'sd90, 8'sd70); // right and bottom on the second frame
        repeat (10) frame();
        repeat (4) randomRun(50);

        // missile and frame in the same cycle, the hit wins and the monster stays put
        @(negedge clk);
        missileHit   = 1'b1;
        startOfFrame = 1'b1;
        @(negedge clk);
        missileHit   = 1'b0;
        startOfFrame = 1'b0;
        mFrozen      = 1'b1;
        mLfsr        = lfsrNext(mLfsr);  // the random stream still steps on that frame
        checkPosition();
        expectRead("status", monsterPkg::REG_STATUS, 16'h0005);
        repeat (5) frame();
        wbWrite(monsterPkg::REG_SPEED_X, 16'h0030);
        wbWrite(monsterPkg::REG_SPEED_Y, 16'hFFD0);
        wbWrite(monsterPkg::REG_CTRL, 16'h0005);   // release, enable stays set
        mVx     = 8'sd48;
        mVy     = -8'sd48;
        mFrozen = 1'b0;
        expectRead("status", monsterPkg::REG_STATUS, 16'h0002);
        repeat (10) frame();

        // disable and re-enable without a load
        wbWrite(monsterPkg::REG_CTRL, 16'h0000);
        mFrozen = 1'b1;
        expectRead("status", monsterPkg::REG_STATUS, 16'h0000);
        repeat (5) frame();
        wbWrite(monsterPkg::REG_CTRL, 16'h0001);
        mFrozen = 1'b0;
        expectRead("status", monsterPkg::REG_STATUS, 16'h0002);
        repeat (10) frame();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/monsterTop.sv
`default_nettype none

`include "monster_config.svh"

module monsterTop (
    input  logic                       clk,
    input  logic                       resetN,
    input  logic                       cyc,
    input  logic                       stb,
    input  logic                       we,
    input  logic [`MON_ADDR_WIDTH-1:0] adr,
    input  logic [`MON_DATA_WIDTH-1:0] datW,
    output logic [`MON_DATA_WIDTH-1:0] datR,
    output logic                       ack,
    input  logic                       startOfFrame, // one cycle pulse per frame
    input  logic                       missileHit    // one cycle pulse from the collision logic
);

    logic                  enable;
    logic                  loadPulse;
    logic                  releasePulse;
    monsterPkg::pixelT     startX;
    monsterPkg::pixelT     startY;
    monsterPkg::speedT     speedX;
    monsterPkg::speedT     speedY;
    monsterPkg::pixelT     minX;
    monsterPkg::pixelT     maxX;
    monsterPkg::pixelT     minY;
    monsterPkg::pixelT     maxY;
    monsterPkg::pixelT     posX;
    monsterPkg::pixelT     posY;
    logic                  isHit;
    monsterPkg::moverState state;
    logic [3:0]            edgeCode;
    logic                  randomBit;

    monsterRegs regs (
        .clk(clk), .resetN(resetN),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datW(datW),
        .posX(posX), .posY(posY), .isHit(isHit), .state(state),
        .datR(datR), .ack(ack),
        .enable(enable), .loadPulse(loadPulse), .releasePulse(releasePulse),
        .startX(startX), .startY(startY), .speedX(speedX), .speedY(speedY),
        .minX(minX), .maxX(maxX), .minY(minY), .maxY(maxY)
    );

    borderSensor border (
        .posX(posX), .posY(posY),
        .minX(minX), .maxX(maxX), .minY(minY), .maxY(maxY),
        .edgeCode(edgeCode)
    );

    // the random stream keeps running even while the monster stands still
    lfsrRandom lfsr (
        .clk(clk), .resetN(resetN),
        .advance(startOfFrame),
        .randomBit(randomBit)
    );

    monsterMover mover (
        .clk(clk), .resetN(resetN),
        .startOfFrame(startOfFrame), .missileHit(missileHit),
        .enable(enable), .loadPulse(loadPulse), .releasePulse(releasePulse),
        .startX(startX), .startY(startY), .speedX(speedX), .speedY(speedY),
        .edgeCode(edgeCode), .randomBit(randomBit),
        .posX(posX), .posY(posY), .isHit(isHit), .state(state)
    );

endmodule

`default_nettype wire

// File: hdl/monsterMover.sv
`default_nettype none

`include "monster_config.svh"

module monsterMover (
    input  logic                  clk,
    input  logic                  resetN,
    input  logic                  startOfFrame,
    input  logic                  missileHit,
    input  logic                  enable,
    input  logic                  loadPulse,
    input  logic                  releasePulse,
    input  monsterPkg::pixelT     startX,
    input  monsterPkg::pixelT     startY,
    input  monsterPkg::speedT     speedX,
    input  monsterPkg::speedT     speedY,
    input  logic [3:0]            edgeCode,
    input  logic                  randomBit,
    output monsterPkg::pixelT     posX,
    output monsterPkg::pixelT     posY,
    output logic                  isHit,
    output monsterPkg::moverState state
);

    monsterPkg::fixedT posXF;     // position in 1/64 pixel
    monsterPkg::fixedT posYF;
    monsterPkg::speedT velX;
    monsterPkg::speedT velY;
    monsterPkg::speedT nextVelX;  // speed after the bounce rule
    monsterPkg::speedT nextVelY;
    logic              hitX;
    logic              hitY;
    logic              loadNow;
    logic              resumeNow;
    logic              stepNow;

    // only a speed pointing into a touched border counts as a hit
    assign hitY = (edgeCode[2] && velY < 0) || (edgeCode[0] && velY > 0);
    assign hitX = (edgeCode[3] && velX < 0) || (edgeCode[1] && velX > 0);

    always_comb begin
        nextVelX = velX;
        nextVelY = velY;
        if (hitX && hitY) begin   // corner, both reverse and no random flip
            nextVelX = -velX;
            nextVelY = -velY;
        end else if (hitY) begin
            nextVelY = -velY;
            if (randomBit) nextVelX = -velX;
        end else if (hitX) begin
            nextVelX = -velX;
            if (randomBit) nextVelY = -velY;
        end
    end

    // a frozen monster ignores loads until it is released
    assign loadNow   = loadPulse && (state != monsterPkg::MOVE_HIT);
    assign resumeNow = releasePulse && (state == monsterPkg::MOVE_HIT);
    assign stepNow   = startOfFrame && !missileHit && enable
                       && (state == monsterPkg::MOVE_RUN); // a hit wins over the frame step

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            state <= monsterPkg::MOVE_IDLE;
        end else begin
            case (state)
                monsterPkg::MOVE_IDLE: if (enable) state <= monsterPkg::MOVE_RUN;
                monsterPkg::MOVE_RUN: begin
                    if (!enable) state <= monsterPkg::MOVE_IDLE;
                    else if (missileHit) state <= monsterPkg::MOVE_HIT;
                end
                monsterPkg::MOVE_HIT: begin
                    if (releasePulse) begin
                        state <= enable ? monsterPkg::MOVE_RUN : monsterPkg::MOVE_IDLE;
                    end
                end
                default: state <= monsterPkg::MOVE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            posXF <= monsterPkg::fixedT'(`MON_INIT_X * (1 << `MON_FRAC_BITS));
            posYF <= monsterPkg::fixedT'(`MON_INIT_Y * (1 << `MON_FRAC_BITS));
            velX  <= monsterPkg::speedT'(`MON_INIT_VX);
            velY  <= monsterPkg::speedT'(`MON_INIT_VY);
        end else if (loadNow) begin
            posXF <= monsterPkg::fixedT'(startX) <<< `MON_FRAC_BITS;
            posYF <= monsterPkg::fixedT'(startY) <<< `MON_FRAC_BITS;
            velX  <= speedX;
            velY  <= speedY;
        end else if (resumeNow) begin // keep the position, take fresh speeds
            velX <= speedX;
            velY <= speedY;
        end else if (stepNow) begin
            posXF <= posXF + monsterPkg::fixedT'(nextVelX); // speeds sign extend here
            posYF <= posYF + monsterPkg::fixedT'(nextVelY);
            velX  <= nextVelX;
            velY  <= nextVelY;
        end
    end

    // dropping the fraction bits is the arithmetic shift by 6
    assign posX  = posXF[`MON_POS_WIDTH-1:`MON_FRAC_BITS];
    assign posY  = posYF[`MON_POS_WIDTH-1:`MON_FRAC_BITS];
    assign isHit = (state == monsterPkg::MOVE_HIT);

    frozenWhileHit: assert property (@(posedge clk) disable iff (!resetN)
        (state == monsterPkg::MOVE_HIT) |=> ($stable(posXF) && $stable(posYF)));

endmodule

`default_nettype wire

// File: hdl/lfsrRandom.sv
`default_nettype none

`include "monster_config.svh"

module lfsrRandom (
    input  logic clk,
    input  logic resetN,
    input  logic advance,   // one step per frame
    output logic randomBit
);

    logic [15:0] lfsrQ;
    logic        feedback;

    // taps 16, 14, 13 and 11 give a maximal length sequence
    assign feedback = lfsrQ[15] ^ lfsrQ[13] ^ lfsrQ[12] ^ lfsrQ[10];

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            lfsrQ <= `MON_LFSR_SEED;
        end else if (advance) begin
            lfsrQ <= {lfsrQ[14:0], feedback};
        end
    end

    // the mover samples this on the same edge that shifts, so it sees the old bit
    assign randomBit = lfsrQ[0];

    lfsrNeverZero: assert property (@(posedge clk) disable iff (!resetN) lfsrQ != '0);

endmodule

`default_nettype wire

// File: hdl/borderSensor.sv
`default_nettype none

`include "monster_config.svh"

module borderSensor (
    input  monsterPkg::pixelT posX,     // top left corner of the sprite
    input  monsterPkg::pixelT posY,
    input  monsterPkg::pixelT minX,
    input  monsterPkg::pixelT maxX,
    input  monsterPkg::pixelT minY,
    input  monsterPkg::pixelT maxY,
    output logic [3:0]        edgeCode  // left, top, right, bottom from bit 3 down
);

    // one extra bit so the far corner cannot wrap near the top of the range
    localparam logic signed [`MON_PIXEL_WIDTH:0] spriteW = `MON_SPRITE_W;
    localparam logic signed [`MON_PIXEL_WIDTH:0] spriteH = `MON_SPRITE_H;

    logic signed [`MON_PIXEL_WIDTH:0] rightX;  // first column right of the sprite
    logic signed [`MON_PIXEL_WIDTH:0] bottomY; // first row below the sprite
    logic                             atLeft;
    logic                             atRight;
    logic                             atTop;
    logic                             atBottom;

    assign rightX  = posX + spriteW;
    assign bottomY = posY + spriteH;

    // at or past a bound counts as touching it
    assign atLeft   = posX <= minX;
    assign atRight  = rightX >= maxX;
    assign atTop    = posY <= minY;
    assign atBottom = bottomY >= maxY;

    // bit order as the mover expects it
    assign edgeCode = {atLeft, atTop, atRight, atBottom};

endmodule

`default_nettype wire

// File: hdl/monsterRegs.sv
`default_nettype none

`include "monster_config.svh"

module monsterRegs (
    input  logic                       clk,
    input  logic                       resetN,
    input  logic                       cyc,
    input  logic                       stb,
    input  logic                       we,
    input  logic [`MON_ADDR_WIDTH-1:0] adr,
    input  logic [`MON_DATA_WIDTH-1:0] datW,
    input  monsterPkg::pixelT          posX,
    input  monsterPkg::pixelT          posY,
    input  logic                       isHit,
    input  monsterPkg::moverState      state,
    output logic [`MON_DATA_WIDTH-1:0] datR,
    output logic                       ack,
    output logic                       enable,
    output logic                       loadPulse,
    output logic                       releasePulse,
    output monsterPkg::pixelT          startX,
    output monsterPkg::pixelT          startY,
    output monsterPkg::speedT          speedX,
    output monsterPkg::speedT          speedY,
    output monsterPkg::pixelT          minX,
    output monsterPkg::pixelT          maxX,
    output monsterPkg::pixelT          minY,
    output monsterPkg::pixelT          maxY
);

    logic                       ackDone;  // ack given, waiting for the master to drop stb
    logic                       request;  // new access accepted on this edge
    logic                       wrEn;
    monsterPkg::regAddr         regSel;
    logic [`MON_DATA_WIDTH-1:0] readMux;

    assign regSel  = monsterPkg::regAddr'(adr); // unmapped codes fall to the default arms
    assign request = cyc && stb && !ack && !ackDone;
    assign wrEn    = request && we;

    // one ack per access, the next one only after stb went low
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            ack     <= 1'b0;
            ackDone <= 1'b0;
        end else begin
            ack     <= request;
            ackDone <= stb && (ackDone || ack); // cleared by the first cycle with stb low
        end
    end

    // load and release are self clearing, they only exist as pulses
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            loadPulse    <= 1'b0;
            releasePulse <= 1'b0;
        end else begin
            loadPulse    <= wrEn && (regSel == monsterPkg::REG_CTRL) && datW[1];
            releasePulse <= wrEn && (regSel == monsterPkg::REG_CTRL) && datW[2];
        end
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            enable <= 1'b0;
            startX <= monsterPkg::pixelT'(`MON_INIT_X);
            startY <= monsterPkg::pixelT'(`MON_INIT_Y);
            speedX <= monsterPkg::speedT'(`MON_INIT_VX);
            speedY <= monsterPkg::speedT'(`MON_INIT_VY);
            minX   <= monsterPkg::pixelT'(`MON_MIN_X);
            maxX   <= monsterPkg::pixelT'(`MON_MAX_X);
            minY   <= monsterPkg::pixelT'(`MON_MIN_Y);
            maxY   <= monsterPkg::pixelT'(`MON_MAX_Y);
        end else if (wrEn) begin
            case (regSel)
                monsterPkg::REG_CTRL:    enable <= datW[0];
                monsterPkg::REG_START_X: startX <= datW[`MON_PIXEL_WIDTH-1:0];
                monsterPkg::REG_START_Y: startY <= datW[`MON_PIXEL_WIDTH-1:0];
                monsterPkg::REG_SPEED_X: speedX <= datW[`MON_SPEED_WIDTH-1:0];
                monsterPkg::REG_SPEED_Y: speedY <= datW[`MON_SPEED_WIDTH-1:0];
                monsterPkg::REG_MIN_X:   minX   <= datW[`MON_PIXEL_WIDTH-1:0];
                monsterPkg::REG_MAX_X:   maxX   <= datW[`MON_PIXEL_WIDTH-1:0];
                monsterPkg::REG_MIN_Y:   minY   <= datW[`MON_PIXEL_WIDTH-1:0];
                monsterPkg::REG_MAX_Y:   maxY   <= datW[`MON_PIXEL_WIDTH-1:0];
                default: ;                        // status and unmapped ignore writes
            endcase
        end
    end

    // signed fields are sign extended to the bus width
    always_comb begin
        case (regSel)
            monsterPkg::REG_CTRL:    readMux = `MON_DATA_WIDTH'(enable);
            monsterPkg::REG_STATUS:  readMux = `MON_DATA_WIDTH'({state, isHit});
            monsterPkg::REG_START_X: readMux = `MON_DATA_WIDTH'(posX);
            monsterPkg::REG_START_Y: readMux = `MON_DATA_WIDTH'(posY);
            monsterPkg::REG_SPEED_X: readMux = `MON_DATA_WIDTH'(speedX);
            monsterPkg::REG_SPEED_Y: readMux = `MON_DATA_WIDTH'(speedY);
            monsterPkg::REG_MIN_X:   readMux = `MON_DATA_WIDTH'(minX);
            monsterPkg::REG_MAX_X:   readMux = `MON_DATA_WIDTH'(maxX);
            monsterPkg::REG_MIN_Y:   readMux = `MON_DATA_WIDTH'(minY);
            monsterPkg::REG_MAX_Y:   readMux = `MON_DATA_WIDTH'(maxY);
            default:                 readMux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (request) begin
            datR <= readMux; // held while ack is high
        end
    end

    ackSinglePulse: assert property (@(posedge clk) disable iff (!resetN) ack |=> !ack);

endmodule

`default_nettype wire

// File: hdl/monsterPkg.sv
`default_nettype none

`include "monster_config.svh"

package monsterPkg;

    // word addresses of the register block
    typedef enum logic [`MON_ADDR_WIDTH-1:0] {
        REG_CTRL    = 4'd0, // bit 0 enable, bit 1 load, bit 2 release
        REG_STATUS  = 4'd1, // read only, bit 0 hit and bits 2:1 state
        REG_START_X = 4'd2, // reads back the current pixel position
        REG_START_Y = 4'd3,
        REG_SPEED_X = 4'd4,
        REG_SPEED_Y = 4'd5,
        REG_MIN_X   = 4'd6,
        REG_MAX_X   = 4'd7,
        REG_MIN_Y   = 4'd8,
        REG_MAX_Y   = 4'd9
    } regAddr;

    // mover FSM states, also visible in the status register
    typedef enum logic [1:0] {
        MOVE_IDLE = 2'd0, // enable is low
        MOVE_RUN  = 2'd1, // moving once per frame
        MOVE_HIT  = 2'd2  // frozen by a missile until released
    } moverState;

    // whole pixel coordinate
    typedef logic signed [`MON_PIXEL_WIDTH-1:0] pixelT;

    // pixel coordinate with the fraction bits below it
    typedef logic signed [`MON_POS_WIDTH-1:0] fixedT;

    // speed in 1/64 pixel per frame, the sign gives the direction
    typedef logic signed [`MON_SPEED_WIDTH-1:0] speedT;

endpackage

`default_nettype wire

// File: hdl/monster_config.svh
`ifndef MONSTER_CONFIG_SVH
`define MONSTER_CONFIG_SVH

// wishbone port widths
`define MON_ADDR_WIDTH 4
`define MON_DATA_WIDTH 16

// coordinates are signed so the sprite can hang partly off screen
`define MON_PIXEL_WIDTH 11
`define MON_FRAC_BITS 6                                   // 1/64 pixel resolution
`define MON_POS_WIDTH (`MON_PIXEL_WIDTH + `MON_FRAC_BITS) // 17 bit fixed point
`define MON_SPEED_WIDTH 8

`define MON_SPRITE_W 32
`define MON_SPRITE_H 32

`define MON_LFSR_SEED 16'hACE1 // any nonzero value keeps the sequence alive

// start position in pixels and start speed in 1/64 pixel per frame
`define MON_INIT_X 300
`define MON_INIT_Y 200
`define MON_INIT_VX 8
`define MON_INIT_VY 0

// default playfield is a 640x480 screen
`define MON_MIN_X 0
`define MON_MAX_X 639
`define MON_MIN_Y 0
`define MON_MAX_Y 479

`endif
